// ==== tb/synth_vectors.txt ====
# B byte(hex) | E channel dir(1 up, 0 down) count(hex) | M word mode(hex)
# W wait cycles | L ena low cycles (decimal) | X verify the current word mode
M 0
B 54
W 200
B 53
W 200
B 51
W 200
B 4E
W 200
B 30
W 600
B 46
W 200
M 3
B 3A
B 51
E 0 1 28
M 1
W 8000
X
M 2
B 4E
W 1500
X
M 3
B 46
W 200
M 1
W 1500
X
L 300
W 200
X

// ==== files.f ====
source/audio_pkg.sv
source/io_pkg.sv
source/command_receiver.sv
source/note_divider.sv
source/wave_bank.sv
source/quadrature_encoder.sv
source/adsr_envelope.sv
source/i2s_transmitter.sv
source/synth_top.sv
tb/synth_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -j 0
TOP       ?= synth_tb
RTL_TOP   ?= synth_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/synth_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module synth_tb;
    import audio_pkg::*;
    import io_pkg::*;

    localparam int enc_step = 1;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    wire  [7:0] uo_out;
    wire  [7:0] uio_out;
    wire  [7:0] uio_oe;

    byte         rec_kind [$];          // Loaded vector records
    int          rec_a1 [$];
    int          rec_a2 [$];
    int          rec_a3 [$];
    int unsigned lcg_state = 32'd46370;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          enc_level [4] = '{0, 0, 0, 0};  // Expected encoder values
    int          word_mode = 3;         // 0 silent, 1 envelope set, 2 noise, 3 unchecked
    bit          peak_seen = 1'b0;
    bit          noise_seen = 1'b0;
    bit          synced = 1'b0;
    logic        last_ws = 1'b0;
    int          bit_count = 0;
    logic [15:0] word = '0;

    synth_top #(.NOTE_SHIFT(12), .ENC_STEP(enc_step)) DUT (
        .ui_in(ui_in), .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out),
        .uio_oe(uio_oe), .ena(ena), .clk(clk), .rst_n(rst_n)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_pins(input i2s_pins_t got, input i2s_pins_t exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
            abort_run("I2S pins wrong");
        end
    endtask

    task automatic check_word(input sample_t got, input sample_t exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
            abort_run("output byte wrong");
        end
    endtask

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Upper byte of 255 times the amplitude
    function automatic sample_t level_byte(input int amp);
        return sample_t'((255 * amp) >> 8);
    endfunction

    function automatic bit in_envelope_set(input sample_t b, input int k);
        for (int a = 0; a <= k; a++) begin
            if (level_byte(a) == b) return 1'b1;
        end
        return 1'b0;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            abort_run("timeout, the run went past its cycle limit");
        end
    end

    task automatic finish_word();
        sample_t hi;
        hi = word[15:8];
        if (bit_count != 16) begin
            abort_run($sformatf("I2S word spanned %0d sck periods instead of 16", bit_count));
        end
        check_word(word[7:0], hi, "lower byte differs from upper byte");
        case (word_mode)
            0: check_word(hi, 8'h00, "word not silent");
            1: begin
                if (in_envelope_set(hi, enc_level[0])) begin
                    if (hi == level_byte(enc_level[0])) peak_seen = 1'b1;
                end else begin
                    check_word(hi, level_byte(enc_level[0]), "word outside envelope levels");
                end
            end
            2: if (hi != 8'h00 && hi != level_byte(enc_level[0])) noise_seen = 1'b1;
            default: ;
        endcase
    endtask

    // Word capture on each rising sck
    always @(posedge uo_out[0]) begin
        i2s_pins_t p;
        p = i2s_pins_t'(uo_out[2:0]);
        if (rst_n) begin
            if (p.ws != last_ws) begin
                if (synced) finish_word();
                synced    = 1'b1;
                bit_count = 0;
                word      = '0;
            end
            word      = {word[14:0], p.sd};
            bit_count = bit_count + 1;
            last_ws   = p.ws;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_byte(input cmd_byte_t b);
        int gap;
        ui_in[0] = 1'b0;                    // Start bit
        next_cycle();
        for (int i = 0; i < 8; i++) begin
            ui_in[0] = b[i];
            next_cycle();
        end
        ui_in[0] = 1'b1;
        lcg_state = lcg_next(lcg_state);
        gap = 2 + int'((lcg_state >> 16) % 6);
        repeat (gap) next_cycle();
    endtask

    task automatic turn_encoder(input int ch, input int up, input int count);
        int pin;
        pin = up ? 2 * ch : 2 * ch + 1;     // Pulse a to count up, b to count down
        repeat (count) begin
            uio_in[pin] = 1'b1;
            next_cycle();
            next_cycle();
            uio_in[pin] = 1'b0;
            next_cycle();
            next_cycle();
            enc_level[ch] = up ? (enc_level[ch] + enc_step) & 255
                               : (enc_level[ch] - enc_step) & 255;
        end
    endtask

    task automatic hold_ena_low(input int n);
        i2s_pins_t frozen;
        ena = 1'b0;
        next_cycle();
        frozen = i2s_pins_t'(uo_out[2:0]);
        repeat (n) begin
            next_cycle();
            check_pins(i2s_pins_t'(uo_out[2:0]), frozen, "I2S pins moved with ena low");
        end
        ena = 1'b1;
    endtask

    task automatic check_reset_outputs();
        check_pins(i2s_pins_t'(uo_out[2:0]), '0, "I2S pins not idle in reset");
        check_word({3'b000, uo_out[7:3]}, 8'h00, "unused uo_out bits");
        check_word(uio_out, 8'h00, "uio_out");
        check_word(uio_oe, 8'h00, "uio_oe");
    endtask

    initial begin
        int    fd;
        int    n;
        int    wait_sum;
        int    a1;
        int    a2;
        int    a3;
        byte   kind;
        string line;
        rst_n    = 1'b0;
        ena      = 1'b1;
        ui_in    = 8'h01;                   // Serial line idles high
        uio_in   = 8'h00;
        wait_sum = 0;
        fd = $fopen("tb/synth_vectors.txt", "r");
        if (fd == 0) abort_run("could not open tb/synth_vectors.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            kind = 8'h20;
            a1 = 0;
            a2 = 0;
            a3 = 0;
            if (n > 0) n = $sscanf(line, "%c", kind);
            case (kind)
                "B", "E", "M": n = $sscanf(line, "%c %h %h %h", kind, a1, a2, a3);
                "W", "L": begin
                    n = $sscanf(line, "%c %d", kind, a1);
                    wait_sum = wait_sum + a1;
                end
                "X", "#", 8'h20, 8'h0A, 8'h0D: ;
                default: abort_run($sformatf("unknown vector record: %s", line));
            endcase
            if (kind != "#" && kind != 8'h20 && kind != 8'h0A && kind != 8'h0D) begin
                rec_kind.push_back(kind);
                rec_a1.push_back(a1);
                rec_a2.push_back(a2);
                rec_a3.push_back(a3);
            end
        end
        $fclose(fd);
        cycle_limit = 2 * wait_sum + 1000;

        repeat (10) begin
            next_cycle();
            check_reset_outputs();
        end
        rst_n = 1'b1;
        check_reset_outputs();              // Still idle right after release

        for (int i = 0; i < rec_kind.size(); i++) begin
            case (rec_kind[i])
                "B": send_byte(cmd_byte_t'(rec_a1[i]));
                "E": turn_encoder(rec_a1[i], rec_a2[i], rec_a3[i]);
                "W": repeat (rec_a1[i]) next_cycle();
                "L": hold_ena_low(rec_a1[i]);
                "M": begin
                    word_mode  = rec_a1[i];
                    peak_seen  = 1'b0;
                    noise_seen = 1'b0;
                end
                "X": begin
                    if (word_mode == 1 && !peak_seen) begin
                        abort_run("no word reached the attack peak level");
                    end
                    if (word_mode == 2 && !noise_seen) begin
                        abort_run("no noise word was seen");
                    end
                end
                default: abort_run("bad record in vector queue");
            endcase
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/synth_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module synth_top #(
    parameter int NOTE_SHIFT = 0,
    parameter int ENC_STEP   = 1
) (
    input  wire [7:0]  ui_in,    // Bit 0 is the serial command line
    output logic [7:0] uo_out,   // Bits 2:0 are {sd, ws, sck}
    input  wire [7:0]  uio_in,   // Four encoder pairs
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  wire        ena,
    input  wire        clk,
    input  wire        rst_n
);
    import audio_pkg::*;
    import io_pkg::*;

    synth_ctrl_t ctrl;
    logic        step;
    adsr_cfg_t   cfg;
    sample_t     wave_sample;
    sample_t     scaled;
    i2s_pins_t   i2s_pins;

    command_receiver u_cmd (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (ui_in[0]),
        .ctrl  (ctrl)
    );

    note_divider #(.NOTE_SHIFT(NOTE_SHIFT)) u_div (
        .clk(clk), .rst_n(rst_n), .ena(ena), .note(ctrl.note), .step(step)
    );

    wave_bank u_wave (
        .clk(clk), .rst_n(rst_n), .ena(ena), .step(step),
        .wave(ctrl.wave), .noise_en(ctrl.noise_en), .sample(wave_sample)
    );

    quadrature_encoder #(.ENC_STEP(ENC_STEP)) u_enc_attack (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .pins(quad_pins_t'(uio_in[1:0])), .value(cfg.attack)
    );
    quadrature_encoder #(.ENC_STEP(ENC_STEP)) u_enc_decay (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .pins(quad_pins_t'(uio_in[3:2])), .value(cfg.decay)
    );
    quadrature_encoder #(.ENC_STEP(ENC_STEP)) u_enc_sustain (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .pins(quad_pins_t'(uio_in[5:4])), .value(cfg.sustain)
    );
    quadrature_encoder #(.ENC_STEP(ENC_STEP)) u_enc_release (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .pins(quad_pins_t'(uio_in[7:6])), .value(cfg.rel)
    );

    adsr_envelope u_env (
        .clk(clk), .rst_n(rst_n), .ena(ena), .step(step),
        .cfg(cfg), .sample(wave_sample), .scaled(scaled)
    );

    i2s_transmitter u_i2s (
        .clk(clk), .rst_n(rst_n), .ena(ena), .sample(scaled), .pins(i2s_pins)
    );

    assign uo_out  = {5'b0, i2s_pins};
    assign uio_out = 8'h00;
    assign uio_oe  = 8'h00;                    // All bidirectional pins are inputs

endmodule

`default_nettype wire

// ==== source/i2s_transmitter.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2s_transmitter (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 ena,
    input  wire audio_pkg::sample_t sample,
    output io_pkg::i2s_pins_t   pins
);
    import audio_pkg::*;
    import io_pkg::*;

    logic [3:0]  bit_cnt;
    logic [15:0] shreg;
    logic        word_end;

    assign word_end = (bit_cnt == 4'd15);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pins    <= '0;
            bit_cnt <= 4'd15;                  // First falling sck opens a word
        end else if (ena) begin
            pins.sck <= ~pins.sck;
            if (pins.sck) begin                // sck about to fall
                bit_cnt <= bit_cnt + 4'd1;
                if (word_end) begin
                    pins.ws <= ~pins.ws;
                    pins.sd <= sample[7];      // MSB goes out with the new ws
                end else begin
                    pins.sd <= shreg[15];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ena && pins.sck) begin
            if (word_end) begin
                shreg <= {sample[6:0], sample, 1'b0};  // Byte twice, MSB already sent
            end else begin
                shreg <= {shreg[14:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/adsr_envelope.sv ====
`timescale 1ns/100ps
`default_nettype none

module adsr_envelope (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   ena,
    input  wire                   step,
    input  wire audio_pkg::adsr_cfg_t cfg,
    input  wire audio_pkg::sample_t   sample,
    output audio_pkg::sample_t    scaled
);
    import audio_pkg::*;

    typedef enum logic [2:0] {
        env_idle,
        env_attack,
        env_decay,
        env_sustain,
        env_release
    } env_state_t;

    env_state_t  state;
    logic [7:0]  step_cnt;
    sample_t     amplitude;
    logic [15:0] product;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= env_idle;
            step_cnt  <= 8'd0;
            amplitude <= '0;
        end else if (ena && step) begin
            case (state)
                env_idle: begin
                    step_cnt <= step_cnt + 8'd1;
                    if (step_cnt == 8'd255) begin
                        state <= env_attack;  // Counter wraps back to 0
                    end
                end
                env_attack: begin
                    if (amplitude < cfg.attack) begin
                        amplitude <= amplitude + 8'd1;
                    end else begin
                        state <= env_decay;
                    end
                end
                env_decay: begin
                    if (amplitude > cfg.sustain) begin
                        // Stop on the sustain level, never below it
                        if (amplitude - cfg.sustain > cfg.decay) begin
                            amplitude <= amplitude - cfg.decay;
                        end else begin
                            amplitude <= cfg.sustain;
                        end
                    end else begin
                        state <= env_sustain;
                    end
                end
                env_sustain: begin
                    amplitude <= cfg.sustain;
                    step_cnt  <= step_cnt + 8'd1;
                    if (step_cnt == 8'd255) begin
                        state <= env_release;
                    end
                end
                env_release: begin
                    if (amplitude == 8'd0) begin
                        state <= env_idle;
                    end else if (amplitude > cfg.rel) begin
                        amplitude <= amplitude - cfg.rel;
                    end else begin
                        amplitude <= 8'd0;     // Clamp at zero
                    end
                end
                default: state <= env_idle;
            endcase
        end
    end

    assign product = 16'(sample) * 16'(amplitude);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scaled <= '0;
        end else if (ena) begin
            scaled <= product[15:8];           // Upper byte of the product
        end
    end

endmodule

`default_nettype wire

// ==== source/quadrature_encoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module quadrature_encoder #(
    parameter int ENC_STEP = 1
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   ena,
    input  wire io_pkg::quad_pins_t pins,
    output audio_pkg::sample_t    value
);
    import audio_pkg::*;
    import io_pkg::*;

    quad_pins_t prev_pins;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_pins <= '0;
            value     <= '0;
        end else if (ena) begin
            prev_pins <= pins;
            case ({pins.a, prev_pins.a, pins.b, prev_pins.b})
                4'b1000, 4'b1101: value <= value + sample_t'(ENC_STEP);  // a up, b low / b down, a high
                4'b0010, 4'b0111: value <= value - sample_t'(ENC_STEP);  // Mirrored pair
                default:          value <= value;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/wave_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module wave_bank (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   ena,
    input  wire                   step,
    input  wire audio_pkg::wave_kind_t wave,
    input  wire                   noise_en,
    output audio_pkg::sample_t    sample
);
    import audio_pkg::*;

    sample_t     tri_level;
    logic        tri_rising;
    sample_t     saw_level;
    logic        sq_high;
    logic [15:0] lfsr;
    sample_t     picked;

    always_comb begin
        if (noise_en) begin
            picked = lfsr[15:8];           // Noise wins over the wave select
        end else begin
            case (wave)
                wave_triangle: picked = tri_level;
                wave_sawtooth: picked = saw_level;
                wave_square:   picked = sq_high ? 8'hFF : 8'h00;
                default:       picked = 8'h00;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tri_level  <= '0;
            tri_rising <= 1'b1;
            saw_level  <= '0;
            sq_high    <= 1'b0;
            lfsr       <= noise_seed;
            sample     <= '0;
        end else if (ena && step) begin
            sample <= picked;
            if (tri_rising) begin
                if (tri_level == 8'hFF) begin
                    tri_rising <= 1'b0;    // Turn at the top
                end else begin
                    tri_level <= tri_level + 8'd1;
                end
            end else begin
                if (tri_level == 8'h00) begin
                    tri_rising <= 1'b1;
                end else begin
                    tri_level <= tri_level - 8'd1;
                end
            end
            saw_level <= saw_level + 8'd1;
            sq_high   <= ~sq_high;
            // Taps 16, 14, 13, 11
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

endmodule

`default_nettype wire

// ==== source/note_divider.sv ====
`timescale 1ns/100ps
`default_nettype none

module note_divider #(
    parameter int NOTE_SHIFT = 0
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   ena,
    input  wire audio_pkg::note_code_t note,
    output logic                  step
);
    import audio_pkg::*;

    localparam period_t reset_period = base_period[0] >> NOTE_SHIFT;  // Note 0

    logic [2:0] octave;
    logic [3:0] semitone;
    period_t    next_period;
    period_t    period_q;
    period_t    count;

    always_comb begin
        if (note < 6'd60) begin
            octave   = 3'(note / 6'd12);
            semitone = 4'(note % 6'd12);
        end else begin
            octave   = 3'd2;               // Spare codes play A4
            semitone = 4'd9;
        end
        next_period = base_period[semitone] >> (32'(octave) + NOTE_SHIFT);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count    <= '0;
            period_q <= reset_period;
        end else if (ena) begin
            if (count == period_q) begin
                count    <= '0;
                period_q <= next_period;   // New note applies at the wrap
            end else begin
                count <= count + 32'd1;
            end
        end
    end

    assign step = ena && (count == period_q);

endmodule

`default_nettype wire

// ==== source/command_receiver.sv ====
`timescale 1ns/100ps
`default_nettype none

module command_receiver (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    rx,    // Serial line, idles high
    output audio_pkg::synth_ctrl_t ctrl
);
    import audio_pkg::*;
    import io_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_receiving,
        st_processing
    } rx_state_t;

    rx_state_t  state;
    logic [2:0] bit_cnt;
    cmd_byte_t  rx_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_cnt <= 3'd0;
            ctrl    <= '0;            // Note 0, triangle, noise off
        end else begin
            case (state)
                st_idle: begin
                    bit_cnt <= 3'd0;
                    if (!rx) begin
                        state <= st_receiving;  // Start bit
                    end
                end
                st_receiving: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= st_processing;
                    end
                end
                st_processing: begin
                    state <= st_idle;
                    case (rx_byte)
                        cmd_noise_on:  ctrl.noise_en <= 1'b1;
                        cmd_noise_off: ctrl.noise_en <= 1'b0;
                        cmd_triangle:  ctrl.wave <= wave_triangle;
                        cmd_sawtooth:  ctrl.wave <= wave_sawtooth;
                        cmd_square:    ctrl.wave <= wave_square;
                        default: begin
                            ctrl.note     <= rx_byte[5:0];  // Anything else picks a note
                            ctrl.wave     <= wave_triangle;
                            ctrl.noise_en <= 1'b0;
                        end
                    endcase
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_receiving) begin
            rx_byte <= {rx, rx_byte[7:1]};  // LSB arrives first
        end
    end

endmodule

`default_nettype wire

// ==== source/io_pkg.sv ====
`default_nettype none

package io_pkg;

    typedef logic [7:0] cmd_byte_t;

    localparam cmd_byte_t cmd_noise_on  = 8'h4E;  // 'N'
    localparam cmd_byte_t cmd_noise_off = 8'h46;  // 'F'
    localparam cmd_byte_t cmd_triangle  = 8'h54;  // 'T'
    localparam cmd_byte_t cmd_sawtooth  = 8'h53;  // 'S'
    localparam cmd_byte_t cmd_square    = 8'h51;  // 'Q'

    // Encoder pin pair, a sits in bit 0
    typedef struct packed {
        logic b;
        logic a;
    } quad_pins_t;

    // Maps onto uo_out[2:0]
    typedef struct packed {
        logic sd;
        logic ws;
        logic sck;
    } i2s_pins_t;

endpackage

`default_nettype wire

// ==== source/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    typedef logic [7:0]  sample_t;    // Audio sample or amplitude
    typedef logic [5:0]  note_code_t; // 0..59 is C2..B6
    typedef logic [31:0] period_t;    // Step period in clocks

    typedef enum logic [1:0] {
        wave_triangle,
        wave_sawtooth,
        wave_square,
        wave_none       // Silence
    } wave_kind_t;

    typedef struct packed {
        note_code_t note;
        wave_kind_t wave;
        logic       noise_en;
    } synth_ctrl_t;

    typedef struct packed {
        sample_t attack;
        sample_t decay;
        sample_t sustain;
        sample_t rel;
    } adsr_cfg_t;

    // Octave 2 periods, C2 up to B2
    localparam period_t base_period [12] = '{
        32'd1915712, 32'd1803586, 32'd1702624, 32'd1607142,
        32'd1515152, 32'd1431731, 32'd1351351, 32'd1275510,
        32'd1204819, 32'd1136364, 32'd1075268, 32'd1017340
    };

    localparam logic [15:0] noise_seed = 16'hACE1;  // LFSR start value

endpackage

`default_nettype wire
